/* rtl/apr_params.svh */
`ifndef APR_PARAMS_SVH
`define APR_PARAMS_SVH

// Bus and register widths
`define APR_WORD_W   18
`define APR_NUM_ERR  8
`define APR_AC_W     4
`define APR_BLOCK_W  3
`define APR_MAGIC_W  9

// Source select width for the fast-memory address mux
`define APR_SRC_W    3

// Diagnostic read function codes
`define APR_DIAG_FUNC_W  3
`define APR_DIAG_FLAGS   3'd0
`define APR_DIAG_ENABLES 3'd1
`define APR_DIAG_BLOCKS  3'd2
`define APR_DIAG_FMADR   3'd3

`endif

/* rtl/aprPkg.sv */
`default_nettype none

`include "apr_params.svh"

package aprPkg;

  // One word as seen on the diagnostic/IO bus
  typedef logic [`APR_WORD_W-1:0] ebusWord;

  // One bit per flag
  // 0 sbus, 1 nxm, 2 io pf, 3 mb par, 4 cdir par, 5 sadr par, 6 pwr, 7 sweep
  typedef logic [`APR_NUM_ERR-1:0] errVec;

  typedef logic [`APR_AC_W-1:0] acNum;

  typedef logic [`APR_BLOCK_W-1:0] blockNum;

  // Microcode magic number field
  typedef logic [`APR_MAGIC_W-1:0] magicField;

  // Fast-memory address source select
  typedef logic [`APR_SRC_W-1:0] fmSrc;

endpackage

`default_nettype wire

/* rtl/aprErrorFlags.sv */
`default_nettype none

`include "apr_params.svh"

module aprErrorFlags (
  input  wire logic           clk,
  input  wire logic           arstN,
  input  wire logic           conoApr,
  input  wire aprPkg::ebusWord conoData,
  input  wire logic           sbusErr,
  input  wire logic           nxmErr,
  input  wire logic           ioPageFail,
  input  wire logic           mbParErr,
  input  wire logic           cacheDirParErr,
  input  wire logic           sbusAdrParErr,
  input  wire logic           pwrWarn,
  input  wire logic           sweepBusy,
  output aprPkg::errVec       errFlags,
  output aprPkg::errVec       intEnables,
  output logic                aprInterrupt,
  output logic                anyErrFlag
);

  // Function bits of the condition-output word
  localparam int ClrBit = 8;
  localparam int SetBit = 9;
  localparam int DisBit = 10;
  localparam int EnBit  = 11;

  aprPkg::errVec conoMask;
  aprPkg::errVec setMask;
  aprPkg::errVec clrMask;
  aprPkg::errVec enMask;
  aprPkg::errVec disMask;
  aprPkg::errVec eventVec;
  aprPkg::errVec flagsNext;
  aprPkg::errVec enablesNext;
  logic          sweepBusyQ;
  logic          sweepDone;

  assign conoMask = conoData[`APR_NUM_ERR-1:0];
  assign setMask  = conoMask & {`APR_NUM_ERR{conoApr & conoData[SetBit]}};
  assign clrMask  = conoMask & {`APR_NUM_ERR{conoApr & conoData[ClrBit]}};
  assign enMask   = conoMask & {`APR_NUM_ERR{conoApr & conoData[EnBit]}};
  assign disMask  = conoMask & {`APR_NUM_ERR{conoApr & conoData[DisBit]}};

  // Sweep finished on the falling edge of busy
  assign sweepDone = sweepBusyQ & ~sweepBusy;

  assign eventVec = {sweepDone, pwrWarn, sbusAdrParErr, cacheDirParErr,
                     mbParErr, ioPageFail, nxmErr, sbusErr};

  // Set and events win over clear
  assign flagsNext   = eventVec | setMask | (errFlags & ~clrMask);
  assign enablesNext = enMask | (intEnables & ~disMask);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      errFlags   <= '0;
      intEnables <= '0;
      sweepBusyQ <= 1'b0;
      anyErrFlag <= 1'b0;
    end else begin
      errFlags   <= flagsNext;
      intEnables <= enablesNext;
      sweepBusyQ <= sweepBusy;
      // nxm, mb parity and sbus address parity
      anyErrFlag <= errFlags[1] | errFlags[3] | errFlags[5];
    end
  end

  assign aprInterrupt = |(errFlags & intEnables);

  // Software must not ask for enable and disable at once
  conoEnDisExclusive: assert property (
    @(posedge clk) disable iff (!arstN)
    conoApr |-> !(conoData[EnBit] && conoData[DisBit])
  ) else $error("CONO APR carries both enable and disable");

endmodule

`default_nettype wire

/* rtl/fastMemAddr.sv */
`default_nettype none

module fastMemAddr (
  input  wire logic             clk,
  input  wire logic             arstN,
  input  wire logic             loadAcBlocks,
  input  wire aprPkg::ebusWord  blockData,
  input  wire logic             loadVmaContext,
  input  wire logic             vmaPrevEn,
  input  wire logic             xrPrevious,
  input  wire aprPkg::acNum     ac,
  input  wire aprPkg::acNum     xr,
  input  wire aprPkg::acNum     vmaLow,
  input  wire aprPkg::magicField magic,
  input  wire aprPkg::fmSrc     src,
  output aprPkg::blockNum       currentBlock,
  output aprPkg::blockNum       prevBlock,
  output aprPkg::blockNum       vmaBlock,
  output aprPkg::acNum          fmAdr,
  output aprPkg::blockNum       fmBlock
);

  aprPkg::blockNum xrBlock;
  aprPkg::blockNum vmaBlockNext;
  aprPkg::acNum    acPlus1;
  aprPkg::acNum    acPlus2;
  aprPkg::acNum    acPlus3;
  aprPkg::acNum    acPlusMagic;
  aprPkg::acNum    magicAdr;
  aprPkg::blockNum magicBlock;

  assign vmaBlockNext = vmaPrevEn ? prevBlock : currentBlock;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      currentBlock <= '0;
      prevBlock    <= '0;
      vmaBlock     <= '0;
    end else begin
      if (loadAcBlocks) begin
        currentBlock <= blockData[2:0];
        prevBlock    <= blockData[5:3];
      end
      // Context captured from the old block values
      if (loadVmaContext) begin
        vmaBlock <= vmaBlockNext;
      end
    end
  end

  assign xrBlock = xrPrevious ? prevBlock : currentBlock;

  assign magicAdr   = magic[3:0];
  assign magicBlock = magic[6:4];

  // AC adders wrap within the 16-word block
  assign acPlus1     = aprPkg::acNum'(ac + 4'd1);
  assign acPlus2     = aprPkg::acNum'(ac + 4'd2);
  assign acPlus3     = aprPkg::acNum'(ac + 4'd3);
  assign acPlusMagic = aprPkg::acNum'(ac + magicAdr);

  always_comb begin
    fmAdr   = ac;
    fmBlock = currentBlock;
    case (src)
      3'd0: begin
        fmAdr = ac;
      end
      3'd1: begin
        fmAdr = acPlus1;
      end
      3'd2: begin
        fmAdr   = xr;
        fmBlock = xrBlock;
      end
      3'd3: begin
        fmAdr   = vmaLow;
        fmBlock = vmaBlock;
      end
      3'd4: begin
        fmAdr = acPlus2;
      end
      3'd5: begin
        fmAdr = acPlus3;
      end
      3'd6: begin
        fmAdr = acPlusMagic;
      end
      default: begin
        // Absolute address straight from microcode
        fmAdr   = magicAdr;
        fmBlock = magicBlock;
      end
    endcase
  end

  srcKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    !$isunknown(src)
  ) else $error("fast-memory source select has unknown bits");

endmodule

`default_nettype wire

/* rtl/aprDiagRead.sv */
`default_nettype none

`include "apr_params.svh"

module aprDiagRead (
  input  wire logic                        diagRead,
  input  wire logic [`APR_DIAG_FUNC_W-1:0] diagFunc,
  input  wire aprPkg::errVec               errFlags,
  input  wire aprPkg::errVec               intEnables,
  input  wire aprPkg::blockNum             currentBlock,
  input  wire aprPkg::blockNum             prevBlock,
  input  wire aprPkg::blockNum             vmaBlock,
  input  wire aprPkg::acNum                fmAdr,
  input  wire aprPkg::blockNum             fmBlock,
  output aprPkg::ebusWord                  diagWord
);

  always_comb begin
    diagWord = '0;
    if (diagRead) begin
      case (diagFunc)
        `APR_DIAG_FLAGS: begin
          diagWord[`APR_NUM_ERR-1:0] = errFlags;
        end
        `APR_DIAG_ENABLES: begin
          diagWord[`APR_NUM_ERR-1:0] = intEnables;
        end
        `APR_DIAG_BLOCKS: begin
          diagWord[2:0] = currentBlock;
          diagWord[5:3] = prevBlock;
          diagWord[8:6] = vmaBlock;
        end
        `APR_DIAG_FMADR: begin
          diagWord[3:0] = fmAdr;
          diagWord[6:4] = fmBlock;
        end
        default: begin
          // Unused codes read as zero
          diagWord = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/aprTop.sv */
`default_nettype none

module aprTop (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire logic              conoApr,
  input  wire aprPkg::ebusWord   conoData,
  input  wire logic              sbusErr,
  input  wire logic              nxmErr,
  input  wire logic              ioPageFail,
  input  wire logic              mbParErr,
  input  wire logic              cacheDirParErr,
  input  wire logic              sbusAdrParErr,
  input  wire logic              pwrWarn,
  input  wire logic              sweepBusy,
  input  wire logic              loadAcBlocks,
  input  wire aprPkg::ebusWord   blockData,
  input  wire logic              loadVmaContext,
  input  wire logic              vmaPrevEn,
  input  wire logic              xrPrevious,
  input  wire aprPkg::acNum      ac,
  input  wire aprPkg::acNum      xr,
  input  wire aprPkg::acNum      vmaLow,
  input  wire aprPkg::magicField magic,
  input  wire aprPkg::fmSrc      src,
  input  wire logic              diagRead,
  input  wire logic [2:0]        diagFunc,
  output logic                   aprInterrupt,
  output logic                   anyErrFlag,
  output aprPkg::acNum           fmAdr,
  output aprPkg::blockNum        fmBlock,
  output aprPkg::ebusWord        diagWord
);

  aprPkg::errVec   errFlags;
  aprPkg::errVec   intEnables;
  aprPkg::blockNum currentBlock;
  aprPkg::blockNum prevBlock;
  aprPkg::blockNum vmaBlock;

  aprErrorFlags flags0 (
    .clk, .arstN, .conoApr, .conoData,
    .sbusErr, .nxmErr, .ioPageFail, .mbParErr,
    .cacheDirParErr, .sbusAdrParErr, .pwrWarn, .sweepBusy,
    .errFlags, .intEnables, .aprInterrupt, .anyErrFlag
  );

  fastMemAddr fmAddr0 (
    .clk, .arstN, .loadAcBlocks, .blockData,
    .loadVmaContext, .vmaPrevEn, .xrPrevious,
    .ac, .xr, .vmaLow, .magic, .src,
    .currentBlock, .prevBlock, .vmaBlock, .fmAdr, .fmBlock
  );

  // Readback sees the same address the fast memory uses
  aprDiagRead diag0 (
    .diagRead, .diagFunc, .errFlags, .intEnables,
    .currentBlock, .prevBlock, .vmaBlock, .fmAdr, .fmBlock,
    .diagWord
  );

endmodule

`default_nettype wire

/* verification/aprClockGen.sv */
`default_nettype none

module aprClockGen (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod  = 20;
  localparam int ResetCycles = 4;

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Release lines up with the stimulus offset
  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #2 arstN = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/aprTb.sv */
`default_nettype none

`include "apr_params.svh"

module aprTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod = 40;
  localparam int NumTests  = 6;
  localparam int TimeoutNs = NumTests * 200 * ClkPeriod;
  // Control nibble of the condition-output word, bits 11..8
  localparam logic [3:0] CtlClr = 4'b0001;
  localparam logic [3:0] CtlSet = 4'b0010;
  localparam logic [3:0] CtlDis = 4'b0100;
  localparam logic [3:0] CtlEn  = 4'b1000;

  logic clk;
  logic arstN;
  logic conoApr;
  logic [17:0] conoData;
  logic sbusErr, nxmErr, ioPageFail, mbParErr;
  logic cacheDirParErr, sbusAdrParErr, pwrWarn, sweepBusy;
  logic loadAcBlocks, loadVmaContext, vmaPrevEn, xrPrevious;
  logic [17:0] blockData;
  logic [3:0] ac, xr, vmaLow;
  logic [8:0] magic;
  logic [2:0] src;
  logic diagRead;
  logic [2:0] diagFunc;
  logic aprInterrupt, anyErrFlag;
  logic [3:0] fmAdr;
  logic [2:0] fmBlock;
  logic [17:0] diagWord;

  // Reference state kept by the testbench
  int errCount = 0;
  logic [7:0] expFlags = '0;
  logic [7:0] expEn = '0;
  logic [2:0] curBlk = '0;
  logic [2:0] prevBlk = '0;
  logic [2:0] vmaBlk = '0;

  aprClockGen clkGen0 (.clk, .arstN);

  aprTop dut0 (.*);

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errCount++;
      $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic readDiag(input logic [2:0] func, output logic [17:0] word);
    diagRead = 1'b1;
    diagFunc = func;
    #1;
    word = diagWord;
  endtask

  task automatic driveEvent(input int idx, input logic v);
    case (idx)
      0: sbusErr = v;
      1: nxmErr = v;
      2: ioPageFail = v;
      3: mbParErr = v;
      4: cacheDirParErr = v;
      5: sbusAdrParErr = v;
      6: pwrWarn = v;
      default: sweepBusy = v;
    endcase
  endtask

  // Sweep done needs a full busy pulse before the fall
  task automatic pulseEvent(input int idx);
    driveEvent(idx, 1'b1);
    step();
    driveEvent(idx, 1'b0);
    if (idx == 7) step();
    expFlags[idx] = 1'b1;
  endtask

  task automatic sendCono(input logic [3:0] ctl, input logic [7:0] mask);
    conoData = {6'd0, ctl, mask};
    conoApr = 1'b1;
    step();
    conoApr = 1'b0;
    conoData = '0;
    expFlags = (ctl[1] ? mask : 8'h00) | (expFlags & ~(ctl[0] ? mask : 8'h00));
    expEn = (ctl[3] ? mask : 8'h00) | (expEn & ~(ctl[2] ? mask : 8'h00));
  endtask

  task automatic loadBlocks(input logic [2:0] cur, input logic [2:0] prev);
    blockData = {12'd0, prev, cur};
    loadAcBlocks = 1'b1;
    step();
    loadAcBlocks = 1'b0;
    curBlk = cur;
    prevBlk = prev;
  endtask

  task automatic loadVma(input logic prevEn);
    vmaPrevEn = prevEn;
    loadVmaContext = 1'b1;
    step();
    loadVmaContext = 1'b0;
    vmaBlk = prevEn ? prevBlk : curBlk;
  endtask

  // Expected {block, address} from the source table
  function automatic logic [6:0] refAddress();
    logic [3:0] a;
    logic [2:0] b;
    b = curBlk;
    case (src)
      3'd0: a = ac;
      3'd1: a = ac + 4'd1;
      3'd2: begin
        a = xr;
        b = xrPrevious ? prevBlk : curBlk;
      end
      3'd3: begin
        a = vmaLow;
        b = vmaBlk;
      end
      3'd4: a = ac + 4'd2;
      3'd5: a = ac + 4'd3;
      3'd6: a = ac + magic[3:0];
      default: begin
        a = magic[3:0];
        b = magic[6:4];
      end
    endcase
    return {b, a};
  endfunction

  task automatic testResetState();
    logic [17:0] w;
    checkVal(32'(aprInterrupt), 32'd0, "aprInterrupt after reset");
    checkVal(32'(anyErrFlag), 32'd0, "anyErrFlag after reset");
    for (int f = 0; f < 8; f++) begin
      readDiag(3'(f), w);
      checkVal(32'(w), 32'd0, "diagWord after reset");
      diagRead = 1'b0;
      #1;
      checkVal(32'(diagWord), 32'd0, "diagWord with diagRead low");
    end
  endtask

  task automatic testSetEnableClear();
    logic [17:0] w;
    for (int i = 0; i < 8; i++) begin
      pulseEvent(i);
      readDiag(`APR_DIAG_FLAGS, w);
      checkVal(32'(w), 32'(expFlags), "flags after event");
      checkVal(32'(aprInterrupt), 32'd0, "aprInterrupt before enable");
      sendCono(CtlEn, 8'(1 << i));
      checkVal(32'(aprInterrupt), 32'd1, "aprInterrupt after enable");
      sendCono(CtlClr, 8'(1 << i));
      checkVal(32'(aprInterrupt), 32'd0, "aprInterrupt after clear");
    end
    sendCono(CtlSet | CtlClr, 8'h24);
    readDiag(`APR_DIAG_FLAGS, w);
    checkVal(32'(w), 32'(expFlags), "flags after set with clear");
    readDiag(`APR_DIAG_ENABLES, w);
    checkVal(32'(w), 32'(expEn), "interrupt enables");
    // Flags and enables are nonzero here
    for (int f = 4; f < 8; f++) begin
      readDiag(3'(f), w);
      checkVal(32'(w), 32'd0, "diagWord for unused code");
    end
    diagRead = 1'b0;
    #1;
    checkVal(32'(diagWord), 32'd0, "diagWord with diagRead low");
    sendCono(CtlClr | CtlDis, 8'hff);
  endtask

  task automatic testSweepDone();
    logic [17:0] w;
    sweepBusy = 1'b1;
    step();
    readDiag(`APR_DIAG_FLAGS, w);
    checkVal(32'(w[7]), 32'd0, "sweep flag while busy");
    step();
    sweepBusy = 1'b0;
    readDiag(`APR_DIAG_FLAGS, w);
    checkVal(32'(w[7]), 32'd0, "sweep flag before edge");
    step();
    expFlags[7] = 1'b1;
    readDiag(`APR_DIAG_FLAGS, w);
    checkVal(32'(w), 32'(expFlags), "flags after sweep end");
    sendCono(CtlClr, 8'h80);
  endtask

  task automatic testAnyError();
    int errIdx[3] = '{1, 3, 5};
    step();
    checkVal(32'(anyErrFlag), 32'd0, "anyErrFlag idle");
    for (int k = 0; k < 3; k++) begin
      pulseEvent(errIdx[k]);
      checkVal(32'(anyErrFlag), 32'd0, "anyErrFlag same edge");
      step();
      checkVal(32'(anyErrFlag), 32'd1, "anyErrFlag one edge later");
      sendCono(CtlClr, 8'hff);
      step();
      checkVal(32'(anyErrFlag), 32'd0, "anyErrFlag after clear");
    end
    pulseEvent(0);
    step();
    checkVal(32'(anyErrFlag), 32'd0, "anyErrFlag from sbus error");
    sendCono(CtlClr, 8'hff);
  endtask

  task automatic testAddrSources();
    logic [6:0] exp;
    logic [17:0] w;
    loadBlocks(3'($urandom), 3'($urandom));
    loadVma(1'($urandom));
    for (int n = 0; n < 200; n++) begin
      step();
      ac = 4'($urandom);
      xr = 4'($urandom);
      vmaLow = 4'($urandom);
      magic = 9'($urandom);
      src = 3'($urandom);
      xrPrevious = 1'($urandom);
      #1;
      exp = refAddress();
      checkVal(32'(fmAdr), 32'(exp[3:0]), $sformatf("fmAdr for src %0d", src));
      checkVal(32'(fmBlock), 32'(exp[6:4]), $sformatf("fmBlock for src %0d", src));
      readDiag(`APR_DIAG_FMADR, w);
      checkVal(32'(w), 32'(exp), $sformatf("address diagnostic word for src %0d", src));
    end
  endtask

  task automatic testBlockRegs();
    logic [17:0] w;
    logic [2:0] cur;
    cur = 3'($urandom);
    loadBlocks(cur, cur ^ 3'(1 + $urandom % 7));
    for (int p = 0; p < 2; p++) begin
      loadVma(1'(p));
      readDiag(`APR_DIAG_BLOCKS, w);
      checkVal(32'(w), 32'({vmaBlk, prevBlk, curBlk}), "blocks diagnostic word");
    end
    src = 3'd2;
    xr = 4'($urandom);
    for (int p = 0; p < 2; p++) begin
      xrPrevious = 1'(p);
      #1;
      checkVal(32'(fmAdr), 32'(xr), "fmAdr for XR source");
      checkVal(32'(fmBlock), 32'(p ? prevBlk : curBlk), "XR block");
    end
  endtask

  initial begin
    void'($urandom(32'hdedbd7f1));
    conoApr = 1'b0;
    conoData = '0;
    {sbusErr, nxmErr, ioPageFail, mbParErr} = '0;
    {cacheDirParErr, sbusAdrParErr, pwrWarn, sweepBusy} = '0;
    {loadAcBlocks, loadVmaContext, vmaPrevEn, xrPrevious} = '0;
    blockData = '0;
    {ac, xr, vmaLow, magic, src} = '0;
    diagRead = 1'b0;
    diagFunc = '0;
    wait (arstN === 1'b1);
    step();
    testResetState();
    testSetEnableClear();
    testSweepDone();
    testAnyError();
    testAddrSources();
    testBlockRegs();
    $display("Checks done with %0d errors", errCount);
    if (errCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: tests still running after %0d ns", TimeoutNs);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/aprPkg.sv
rtl/aprErrorFlags.sv
rtl/fastMemAddr.sv
rtl/aprDiagRead.sv
rtl/aprTop.sv
verification/aprClockGen.sv
verification/aprTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= aprTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
